/* Makefile */
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

SRCS := $(wildcard hdl/*.sv) $(wildcard dv/*.sv) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/lsu_bus_mem.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_bus_mem
	import lsu_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  cache_bus_req_t  bus_req_i,
	output cache_bus_resp_t bus_resp_o
);

	logic [31:0] mem [256];
	logic [31:0] rdata_q;
	logic        in_data;
	logic [1:0]  cnt;
	int          i;

	// fill depends on every address bit of the word index
	initial begin
		for (i = 0; i < 256; i++) begin
			mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h33, i[7:0] ^ 8'hc3};
		end
	end

	always_comb begin
		bus_resp_o.ready = ~in_data & bus_req_i.valid & (cnt == 2'd0);
		bus_resp_o.data_ok = in_data & (cnt == 2'd0);
		bus_resp_o.data_last = in_data & (cnt == 2'd0);
		bus_resp_o.r_data = rdata_q;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_data <= 1'b0;
			cnt <= 2'($urandom % 4);
		end else if (!in_data) begin
			if (bus_req_i.valid && cnt == 2'd0) begin
				rdata_q <= mem[bus_req_i.addr[9:2]];
				if (bus_req_i.write) begin
					for (int b = 0; b < 4; b++) begin
						if (bus_req_i.data_strobe[b]) begin
							mem[bus_req_i.addr[9:2]][8*b +: 8] <= bus_req_i.w_data[8*b +: 8];
						end
					end
				end
				in_data <= 1'b1;
				cnt <= 2'($urandom % 4);
			end else if (bus_req_i.valid) begin
				cnt <= cnt - 2'd1;
			end
		end else if (cnt == 2'd0) begin
			in_data <= 1'b0;
			cnt <= 2'($urandom % 4);
		end else begin
			cnt <= cnt - 2'd1;
		end
	end

endmodule

/* dv/lsu_chk.sv */
`timescale 1ns/1ps

module lsu_chk
	import lsu_pkg::*;
(
	input logic            clk,
	input logic            rst_n,
	input logic            stall_i,
	input logic            busy_o,
	input logic            load_done_o,
	input logic            store_done_o,
	input lsu_exc_t        exc_o,
	input cache_bus_req_t  bus_req_o,
	input cache_bus_resp_t bus_resp_i
);

	logic xfer_open;

	// open from the address handshake to the slave's last data beat
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			xfer_open <= 1'b0;
		end else if (bus_req_o.valid && bus_resp_i.ready) begin
			xfer_open <= 1'b1;
		end else if (bus_resp_i.data_ok && bus_resp_i.data_last) begin
			xfer_open <= 1'b0;
		end
	end

	reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !bus_req_o.valid && !bus_req_o.data_ok && !busy_o &&
			!load_done_o && !store_done_o)
		else $error("outputs not quiet after reset");

	reset_no_exc: assert property (@(posedge clk) !rst_n |-> !exc_o.valid)
		else $error("exception reported during reset");

	// request must hold until the slave takes it
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		bus_req_o.valid && !bus_resp_i.ready |=> bus_req_o.valid &&
			$stable(bus_req_o.addr) && $stable(bus_req_o.write) &&
			$stable(bus_req_o.w_data) && $stable(bus_req_o.data_strobe))
		else $error("bus request changed before ready");

	busy_open: assert property (@(posedge clk) disable iff (!rst_n)
		xfer_open |-> busy_o)
		else $error("busy_o low during an open transfer");

	// a rejected op never reaches the bus
	exc_no_bus: assert property (@(posedge clk) disable iff (!rst_n)
		exc_o.valid && !busy_o && !stall_i |=> !bus_req_o.valid [*3])
		else $error("bus access after address error");

endmodule

bind lsu_top lsu_chk u_chk (.*);

/* dv/lsu_clk_gen.sv */
`timescale 1ns/1ps

module lsu_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset low for two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb import lsu_pkg::*; ();

	localparam int NUM_OPS = 60;

	logic            clk;
	logic            rst_n;
	mem_op_t         mem_op [`LSU_ISSUE_WIDTH];
	logic [31:0]     vaddr  [`LSU_ISSUE_WIDTH];
	logic [31:0]     w_data [`LSU_ISSUE_WIDTH];
	logic            stall_i;
	logic            stall_en;
	logic            busy_o;
	logic [31:0]     r_data_o;
	logic            load_done_o;
	logic            store_done_o;
	lsu_exc_t        exc_o;
	cache_bus_req_t  bus_req;
	cache_bus_resp_t bus_resp;
	logic [31:0]     shadow [256];
	logic [31:0]     exp_q [$];
	string           name_q [$];
	logic [31:0]     exp_val;
	string           exp_name;

	lsu_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

	lsu_top uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_op_i     (mem_op),
		.vaddr_i      (vaddr),
		.w_data_i     (w_data),
		.stall_i      (stall_i),
		.busy_o       (busy_o),
		.r_data_o     (r_data_o),
		.load_done_o  (load_done_o),
		.store_done_o (store_done_o),
		.exc_o        (exc_o),
		.bus_req_o    (bus_req),
		.bus_resp_i   (bus_resp)
	);

	lsu_bus_mem u_mem (.clk(clk), .rst_n(rst_n), .bus_req_i(bus_req), .bus_resp_o(bus_resp));

	function automatic logic [31:0] fill_word(int idx);
		logic [7:0] i;
		i = idx[7:0];
		return {i ^ 8'h5a, ~i, i + 8'h33, i ^ 8'hc3};
	endfunction

	function automatic logic [31:0] to_paddr(logic [31:0] va);
		if (va[31:30] == 2'b10) begin
			return va & 32'h1fff_ffff;
		end
		return va;
	endfunction

	function automatic logic [3:0] lane_mask(logic [1:0] size, logic [1:0] lo);
		if (size == 2'd0) begin
			return 4'b0001 << lo;
		end else if (size == 2'd1) begin
			return 4'b0011 << lo;
		end
		return 4'b1111;
	endfunction

	// expected load result from a memory word
	function automatic logic [31:0] load_value(logic [31:0] word, logic [2:0] mtype,
		logic [1:0] lo);
		logic [31:0] sh;
		sh = word >> (8 * lo);
		if (mtype[1:0] == 2'd0) begin
			return mtype[2] ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
		end else if (mtype[1:0] == 2'd1) begin
			return mtype[2] ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
		end
		return word;
	endfunction

	task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
		$display("Fail %s expected %h actual %h", name, expected, actual);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic issue_op(string name, bit slot, bit wr, logic [2:0] mtype,
		logic [31:0] va, logic [31:0] wd, bit both);
		bit          accepted;
		bit          done;
		bit          mis;
		logic [31:0] pa;
		logic [31:0] sh;
		logic [3:0]  strb;
		int          idx;
		mis = (mtype[1:0] == 2'd1 && va[0]) || (mtype[1:0] == 2'd2 && va[1:0] != 2'd0);
		@(posedge clk);
		mem_op[slot] <= '{1'b1, wr, mtype};
		vaddr[slot] <= va;
		w_data[slot] <= wd;
		if (both) begin
			mem_op[!slot] <= '{1'b1, ~wr, 3'b010};
			vaddr[!slot] <= 32'h8000_03f0;
			w_data[!slot] <= 32'hdead_beef;
		end else begin
			mem_op[!slot] <= '0;
		end
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = !busy_o && !stall_i;
		end
		if (mis) begin
			assert (exc_o == lsu_exc_t'{1'b1, wr, slot})
				else report_mismatch(name, {29'h0, 1'b1, wr, slot}, {29'h0, exc_o});
		end else begin
			assert (!exc_o.valid) else report_mismatch(name, 32'h0, {29'h0, exc_o});
		end
		@(posedge clk);
		mem_op[0] <= '0;
		mem_op[1] <= '0;
		if (mis) begin
			repeat (4) @(posedge clk);
		end else begin
			pa = to_paddr(va);
			idx = int'(pa[9:2]);
			if (wr) begin
				sh = wd << (8 * pa[1:0]);
				strb = lane_mask(mtype[1:0], pa[1:0]);
				for (int b = 0; b < 4; b++) begin
					if (strb[b]) begin
						shadow[idx][8*b +: 8] = sh[8*b +: 8];
					end
				end
			end else begin
				exp_q.push_back(load_value(shadow[idx], mtype, pa[1:0]));
				name_q.push_back(name);
			end
			done = 1'b0;
			while (!done) begin
				@(negedge clk);
				done = load_done_o || store_done_o;
			end
			// the done flag must match the kind of access
			assert (store_done_o == wr)
				else report_mismatch(name, {31'h0, wr}, {31'h0, store_done_o});
		end
	endtask

	always @(posedge clk) begin
		stall_i <= stall_en && ($urandom % 4 == 0);
	end

	// compare each load result with the oldest expected value
	always @(negedge clk) begin
		if (rst_n && load_done_o) begin
			if (exp_q.size() == 0) begin
				$display("load_done_o pulsed with no load pending");
				$display("TEST FAILED");
				$fatal(1);
			end else begin
				exp_val = exp_q.pop_front();
				exp_name = name_q.pop_front();
				assert (r_data_o == exp_val) else report_mismatch(exp_name, exp_val, r_data_o);
			end
		end
	end

	initial begin
		repeat (NUM_OPS * 200) @(posedge clk);
		$display("watchdog expired before all operations completed");
		$display("TEST FAILED");
		$fatal(1);
	end

	initial begin
		int          sz;
		bit          wr;
		bit          uns;
		bit          slot;
		bit          both;
		logic [1:0]  lo;
		logic [31:0] base;
		logic [31:0] va;
		void'($urandom(6892));
		mem_op[0] = '0;
		mem_op[1] = '0;
		vaddr[0] = '0;
		vaddr[1] = '0;
		w_data[0] = '0;
		w_data[1] = '0;
		stall_i = 1'b0;
		stall_en = 1'b0;
		for (int i = 0; i < 256; i++) begin
			shadow[i] = fill_word(i);
		end
		wait (rst_n);
		repeat (2) @(posedge clk);

		issue_op("word_st", 0, 1, 3'b010, 32'ha000_0100, 32'h1234_5678, 0);
		issue_op("word_ld_kseg1", 0, 0, 3'b010, 32'ha000_0100, 32'h0, 0);
		issue_op("word_ld_phys", 0, 0, 3'b010, 32'h0000_0100, 32'h0, 0);

		issue_op("sb_lane1", 0, 1, 3'b000, 32'h8000_0205, 32'h0000_009c, 0);
		issue_op("sh_lane2", 1, 1, 3'b001, 32'h8000_0206, 32'h0000_8a11, 0);
		issue_op("lw_merged", 0, 0, 3'b010, 32'h8000_0204, 32'h0, 0);
		issue_op("lb_lane1", 0, 0, 3'b000, 32'h8000_0205, 32'h0, 0);
		issue_op("lbu_lane1", 1, 0, 3'b100, 32'h8000_0205, 32'h0, 0);
		issue_op("lh_lane2", 0, 0, 3'b001, 32'h8000_0206, 32'h0, 0);
		issue_op("lhu_lane2", 1, 0, 3'b101, 32'h8000_0206, 32'h0, 0);
		issue_op("lb_lane0", 0, 0, 3'b000, 32'h8000_0204, 32'h0, 0);
		issue_op("lbu_lane3", 0, 0, 3'b100, 32'h8000_0207, 32'h0, 0);

		issue_op("prio_st", 1, 1, 3'b010, 32'h8000_0300, 32'hcafe_f00d, 1);
		issue_op("prio_ld", 1, 0, 3'b010, 32'h8000_0300, 32'h0, 1);

		issue_op("mis_lw", 0, 0, 3'b010, 32'h8000_0101, 32'h0, 0);
		issue_op("mis_sw", 1, 1, 3'b010, 32'h8000_0102, 32'h1111_2222, 0);
		issue_op("mis_sh", 0, 1, 3'b001, 32'ha000_0013, 32'h3333_4444, 0);
		issue_op("mis_lh", 1, 0, 3'b101, 32'h0000_0021, 32'h0, 0);

		stall_en = 1'b1;
		repeat (40) begin
			sz = $urandom % 3;
			wr = 1'($urandom % 2);
			uns = 1'($urandom % 2);
			slot = 1'($urandom % 2);
			both = slot && ($urandom % 2 == 1);
			lo = 2'($urandom % 4);
			if (sz == 1) begin
				lo[0] = 1'b0;
			end else if (sz == 2) begin
				lo = 2'd0;
			end
			case ($urandom % 3)
				0: base = 32'h8000_0000;
				1: base = 32'ha000_0000;
				default: base = 32'h0000_0000;
			endcase
			va = base | (32'($urandom % 256) << 2) | {30'h0, lo};
			issue_op("random", slot, wr, {uns & (sz != 2), 2'(sz)}, va, $urandom, both);
		end
		stall_en = 1'b0;

		repeat (10) @(posedge clk);
		if (exp_q.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("Fail pending_loads expected 0 actual %0d", exp_q.size());
			$display("TEST FAILED");
			$fatal(1);
		end
	end

endmodule

/* hdl/load_align.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_align (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    done_i,
	input  logic                    write_i,
	input  logic [2:0]              mem_type_i,
	input  logic [1:0]              addr_lo_i,
	input  logic [`LSU_DATA_W-1:0]  r_data_i,
	output logic [`LSU_DATA_W-1:0]  r_data_o,
	output logic                    load_done_o,
	output logic                    store_done_o
);

	logic [`LSU_DATA_W-1:0] shifted;
	logic [`LSU_DATA_W-1:0] ext;
	logic                   sign_en;
	logic [`LSU_DATA_W-1:0] r_data_q;
	logic                   load_done_q;
	logic                   store_done_q;

	// addressed lane down to bit 0
	assign shifted = r_data_i >> {addr_lo_i, 3'b000};
	assign sign_en = ~mem_type_i[2];

	always_comb begin
		case (mem_type_i[1:0])
			`LSU_MEM_TYPE_BYTE: begin
				ext = {{24{shifted[7] & sign_en}}, shifted[7:0]};
			end
			`LSU_MEM_TYPE_HALF: begin
				ext = {{16{shifted[15] & sign_en}}, shifted[15:0]};
			end
			default: begin
				ext = r_data_i;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (done_i & ~write_i) begin
			r_data_q <= ext;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			load_done_q <= 1'b0;
			store_done_q <= 1'b0;
		end else begin
			load_done_q <= done_i & ~write_i;
			store_done_q <= done_i & write_i;
		end
	end

	assign r_data_o = r_data_q;
	assign load_done_o = load_done_q;
	assign store_done_o = store_done_q;

endmodule

/* hdl/lsu_bus_fsm.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_bus_fsm
	import lsu_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  lsu_req_t         req_i,
	input  logic             stall_i,
	output logic             busy_o,
	output cache_bus_req_t   bus_req_o,
	input  cache_bus_resp_t  bus_resp_i,
	output logic             done_o,
	output logic [2:0]       done_type_o,
	output logic [1:0]       done_addr_o,
	output logic             done_write_o
);

	localparam logic [2:0] STATE_IDLE = 3'b001;
	localparam logic [2:0] STATE_ADDR = 3'b010;
	localparam logic [2:0] STATE_DATA = 3'b100;

	lsu_req_t   s1_q;
	lsu_req_t   s2_q;
	logic [2:0] state_q;
	logic [2:0] state_d;
	logic       advance;
	logic       transfer_done;

	assign busy_o = (state_q != STATE_IDLE) | s2_q.valid;
	assign advance = ~busy_o & ~stall_i;

	// both stages move together, only the valid bits see reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_q.valid <= 1'b0;
			s2_q.valid <= 1'b0;
		end else if (advance) begin
			s1_q <= req_i;
			s2_q <= s1_q;
		end else if (transfer_done) begin
			s2_q.valid <= 1'b0;
		end
	end

	// both sides must show data_ok and the last beat
	assign transfer_done = (state_q == STATE_DATA) & bus_req_o.data_ok & bus_resp_i.data_ok &
		bus_req_o.data_last & bus_resp_i.data_last;

	always_comb begin
		state_d = state_q;
		case (state_q)
			STATE_IDLE: begin
				if (s2_q.valid) begin
					state_d = STATE_ADDR;
				end
			end
			STATE_ADDR: begin
				if (bus_resp_i.ready) begin
					state_d = STATE_DATA;
				end
			end
			STATE_DATA: begin
				if (transfer_done) begin
					state_d = STATE_IDLE;
				end
			end
			default: begin
				state_d = STATE_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= STATE_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// request fields come straight from stage 2, held while busy
	always_comb begin
		bus_req_o.valid = (state_q == STATE_ADDR);
		bus_req_o.write = s2_q.write;
		bus_req_o.burst = 1'b0;
		bus_req_o.cached = 1'b0;
		bus_req_o.addr = s2_q.paddr;
		bus_req_o.w_data = s2_q.w_data;
		bus_req_o.data_strobe = s2_q.strobe;
		bus_req_o.data_ok = (state_q == STATE_DATA);
		bus_req_o.data_last = (state_q == STATE_DATA);
	end

	assign done_o = transfer_done;
	assign done_type_o = s2_q.mem_type;
	assign done_addr_o = s2_q.paddr[1:0];
	assign done_write_o = s2_q.write;

endmodule

/* hdl/lsu_pkg.sv */
`include "lsu_macros.svh"

package lsu_pkg;

	// one slot's memory op, mem_type[2] set means unsigned load
	typedef struct packed {
		logic       mem_valid;
		logic       mem_write;
		logic [2:0] mem_type;
	} mem_op_t;

	// decoded request, decode to execute
	typedef struct packed {
		logic                      valid;
		logic                      write;
		logic [2:0]                mem_type;
		logic [31:0]               paddr;
		logic [`LSU_DATA_W/8-1:0]  strobe;
		logic [`LSU_DATA_W-1:0]    w_data;
	} lsu_req_t;

	// cache bus request, uncached single beat only
	typedef struct packed {
		logic                      valid;
		logic                      write;
		logic                      burst;
		logic                      cached;
		logic [31:0]               addr;
		logic [`LSU_DATA_W-1:0]    w_data;
		logic [`LSU_DATA_W/8-1:0]  data_strobe;
		logic                      data_ok;
		logic                      data_last;
	} cache_bus_req_t;

	// cache bus response from memory
	typedef struct packed {
		logic                      ready;
		logic                      data_ok;
		logic                      data_last;
		logic [`LSU_DATA_W-1:0]    r_data;
	} cache_bus_resp_t;

	// address error report, store set means AdES
	typedef struct packed {
		logic valid;
		logic store;
		logic slot;
	} lsu_exc_t;

endpackage

/* hdl/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top
	import lsu_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  mem_op_t                 mem_op_i [`LSU_ISSUE_WIDTH],
	input  logic [31:0]             vaddr_i  [`LSU_ISSUE_WIDTH],
	input  logic [`LSU_DATA_W-1:0]  w_data_i [`LSU_ISSUE_WIDTH],
	input  logic                    stall_i,
	output logic                    busy_o,
	output logic [`LSU_DATA_W-1:0]  r_data_o,
	output logic                    load_done_o,
	output logic                    store_done_o,
	output lsu_exc_t                exc_o,
	output cache_bus_req_t          bus_req_o,
	input  cache_bus_resp_t         bus_resp_i
);

	lsu_req_t   dec_req;
	logic       done;
	logic [2:0] done_type;
	logic [1:0] done_addr;
	logic       done_write;

	mem_op_decode u_decode (
		.mem_op_i (mem_op_i),
		.vaddr_i  (vaddr_i),
		.w_data_i (w_data_i),
		.req_o    (dec_req),
		.exc_o    (exc_o)
	);

	lsu_bus_fsm u_bus_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_i        (dec_req),
		.stall_i      (stall_i),
		.busy_o       (busy_o),
		.bus_req_o    (bus_req_o),
		.bus_resp_i   (bus_resp_i),
		.done_o       (done),
		.done_type_o  (done_type),
		.done_addr_o  (done_addr),
		.done_write_o (done_write)
	);

	// result stage works off the raw bus read data
	load_align u_load_align (
		.clk          (clk),
		.rst_n        (rst_n),
		.done_i       (done),
		.write_i      (done_write),
		.mem_type_i   (done_type),
		.addr_lo_i    (done_addr),
		.r_data_i     (bus_resp_i.r_data),
		.r_data_o     (r_data_o),
		.load_done_o  (load_done_o),
		.store_done_o (store_done_o)
	);

endmodule

/* hdl/mem_op_decode.sv */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module mem_op_decode
	import lsu_pkg::*;
(
	input  mem_op_t                         mem_op_i [`LSU_ISSUE_WIDTH],
	input  logic [31:0]                     vaddr_i  [`LSU_ISSUE_WIDTH],
	input  logic [`LSU_DATA_W-1:0]          w_data_i [`LSU_ISSUE_WIDTH],
	output lsu_req_t                        req_o,
	output lsu_exc_t                        exc_o
);

	logic                     sel;
	mem_op_t                  op;
	logic [31:0]              vaddr;
	logic [31:0]              paddr;
	logic [`LSU_DATA_W-1:0]   wdata;
	logic [`LSU_DATA_W/8-1:0] strobe;
	logic                     misaligned;

	// slot 1 has priority
	always_comb begin
		sel = mem_op_i[1].mem_valid;
		op = mem_op_i[sel];
		vaddr = vaddr_i[sel];
		wdata = w_data_i[sel];
	end

	// kseg0/kseg1 drop the top three bits, mapped segments pass through
	always_comb begin
		case (vaddr[31:29])
			3'b100, 3'b101: paddr = {3'b000, vaddr[28:0]};
			default: paddr = vaddr;
		endcase
	end

	always_comb begin
		strobe = '0;
		misaligned = 1'b0;
		case (op.mem_type[1:0])
			`LSU_MEM_TYPE_BYTE: begin
				strobe = 4'b0001 << vaddr[1:0];
			end
			`LSU_MEM_TYPE_HALF: begin
				strobe = 4'b0011 << {vaddr[1], 1'b0};
				misaligned = vaddr[0];
			end
			`LSU_MEM_TYPE_WORD: begin
				strobe = 4'b1111;
				misaligned = |vaddr[1:0];
			end
			default: begin
				strobe = '0;
			end
		endcase
	end

	always_comb begin
		req_o.valid = op.mem_valid & ~misaligned;
		req_o.write = op.mem_write;
		req_o.mem_type = op.mem_type;
		req_o.paddr = paddr;
		req_o.strobe = strobe;
		// move store data into its byte lane
		req_o.w_data = wdata << {vaddr[1:0], 3'b000};
	end

	always_comb begin
		exc_o.valid = op.mem_valid & misaligned;
		exc_o.store = op.mem_write;
		exc_o.slot = sel;
	end

endmodule

/* include/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// access size codes, low two bits of mem_type
`define LSU_MEM_TYPE_BYTE 2'b00
`define LSU_MEM_TYPE_HALF 2'b01
`define LSU_MEM_TYPE_WORD 2'b10

// issue slots feeding the unit
`define LSU_ISSUE_WIDTH 2

// uncached bus data width
`define LSU_DATA_W 32

`endif

/* vlog.f */
+incdir+include
hdl/lsu_pkg.sv
hdl/mem_op_decode.sv
hdl/lsu_bus_fsm.sv
hdl/load_align.sv
hdl/lsu_top.sv
dv/lsu_clk_gen.sv
dv/lsu_bus_mem.sv
dv/lsu_chk.sv
dv/lsu_tb.sv
